//--- common/cordic_config.svh
`ifndef CORDIC_CONFIG_SVH
`define CORDIC_CONFIG_SVH

// Single precision word and its fields.
`define CORDIC_W 32 // Full word width.
`define CORDIC_E 8 // Exponent field width.
`define CORDIC_M 23 // Mantissa field width.

// Number of rotations per computation. This also sets the arctangent table depth.
`define CORDIC_ITERS 16

// Start value of X is the inverse CORDIC gain, 0.607252935.
`define CORDIC_X0 32'h3f1b74ee

`endif

//--- common/cordic_ctrl_pkg.sv
`default_nettype none

package cordic_ctrl_pkg;

	// Sequencer states, in the order one computation walks through them.
	typedef enum logic [2:0]
	{
		ST_IDLE, // Waiting for a start pulse.
		ST_LOAD, // Counters cleared, inputs already captured.
		ST_SNAP, // Shifted copies, table entry and direction registered.
		ST_REQUEST, // Start strobe to the adder.
		ST_WAIT, // Operands held until the adder is ready.
		ST_NEXT, // Step to the next rotation or finish.
		ST_LATCH, // Final value goes to the output register.
		ST_DONE // Result held until the consumer acknowledges.
	} fsm_state_t;

	// Which variable the current adder exchange updates.
	typedef enum logic [1:0]
	{
		VAR_X = 2'd0,
		VAR_Y = 2'd1,
		VAR_Z = 2'd2
	} var_sel_t;

	// Quadrant folding done outside, used here only to fix the result sign.
	typedef logic [1:0] region_t;

	// Strobes from the sequencer to the datapath.
	typedef struct packed
	{
		logic load_init; // Capture angle and flags, preset X and Y.
		logic snap; // Take shifted copies and the table entry.
		logic load_x; // Adder result into X.
		logic load_y; // Adder result into Y.
		logic load_z; // Adder result into Z.
		var_sel_t var_sel; // Operand and operation select.
		logic latch_out; // Load the output register.
	} cordic_ctrl_t;

endpackage

`default_nettype wire

//--- common/cordic_float_pkg.sv
`default_nettype none

`include "cordic_config.svh"

package cordic_float_pkg;

	// Field view of an IEEE 754 single precision word.
	typedef struct packed
	{
		logic sign; // One means negative.
		logic [`CORDIC_E-1:0] exponent; // Biased by 127.
		logic [`CORDIC_M-1:0] mantissa; // Hidden bit not stored.
	} float_fields_t;

	// The datapath moves raw words but the shifter and the sign fix need the fields.
	typedef union packed
	{
		logic [`CORDIC_W-1:0] raw;
		float_fields_t fields;
	} float_word_t;

	// Index of the current rotation.
	typedef logic [$clog2(`CORDIC_ITERS)-1:0] iter_t;

endpackage

`default_nettype wire

//--- cordic_coprocessor.f
+incdir+common
common/cordic_float_pkg.sv
common/cordic_ctrl_pkg.sv
datapath/xy_rotator.sv
datapath/angle_path.sv
datapath/iteration_combiner.sv
hw/cordic_fsm.sv
hw/cordic_coprocessor.sv
verif/tb_cordic_coprocessor.sv

//--- datapath/angle_path.sv
`timescale 1ns/10ps
`default_nettype none

`include "cordic_config.svh"

module angle_path import cordic_float_pkg::*, cordic_ctrl_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire cordic_ctrl_t ctrl,
	input wire iter_t iter,
	input wire float_word_t data_in,
	input wire float_word_t result_add_subt,
	input wire logic operation,
	input wire region_t shift_region_flag,
	output float_word_t z_cur, // Residual angle.
	output float_word_t atan_entry,
	output logic rotate_neg, // Rotate clockwise this iteration.
	output logic op_reg,
	output region_t region_reg
);

	float_word_t atan_rom;

	// atan(2^-i) in single precision. Past i = 11 it equals 2^-i.
	always_comb
	begin
		case (iter)
			4'd0: atan_rom.raw = 32'h3f490fdb;
			4'd1: atan_rom.raw = 32'h3eed6338;
			4'd2: atan_rom.raw = 32'h3e7adbb0;
			4'd3: atan_rom.raw = 32'h3dfeadd5;
			4'd4: atan_rom.raw = 32'h3d7faade;
			4'd5: atan_rom.raw = 32'h3cffeaae;
			4'd6: atan_rom.raw = 32'h3c7ffaab;
			4'd7: atan_rom.raw = 32'h3bfffeab;
			4'd8: atan_rom.raw = 32'h3b7fffab;
			4'd9: atan_rom.raw = 32'h3affffeb;
			4'd10: atan_rom.raw = 32'h3a7ffffb;
			4'd11: atan_rom.raw = 32'h39ffffff;
			4'd12: atan_rom.raw = 32'h39800000;
			4'd13: atan_rom.raw = 32'h39000000;
			4'd14: atan_rom.raw = 32'h38800000;
			default: atan_rom.raw = 32'h38000000;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.load_init)
			z_cur <= data_in; // The angle starts as the residual.
		else if (ctrl.load_z)
			z_cur <= result_add_subt;
		if (ctrl.snap)
		begin
			atan_entry <= atan_rom;
			rotate_neg <= z_cur.fields.sign; // Drive Z toward zero.
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			op_reg <= 1'b0;
			region_reg <= '0;
		end
		else if (ctrl.load_init)
		begin
			op_reg <= operation;
			region_reg <= shift_region_flag;
		end
	end

	// Each snapshot reads the next table entry, or the first one of a new computation.
	assert property (@(posedge clk) disable iff (reset)
		ctrl.snap |-> (iter == '0 || iter == iter_t'($past(iter) + 1'b1)))
		else $error("table index did not step to the next rotation");

endmodule

`default_nettype wire

//--- datapath/iteration_combiner.sv
`timescale 1ns/10ps
`default_nettype none

module iteration_combiner import cordic_float_pkg::*, cordic_ctrl_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire cordic_ctrl_t ctrl,
	input wire float_word_t x_cur,
	input wire float_word_t y_cur,
	input wire float_word_t x_shifted,
	input wire float_word_t y_shifted,
	input wire float_word_t z_cur,
	input wire float_word_t atan_entry,
	input wire logic rotate_neg,
	input wire logic op_reg, // One for sine.
	input wire region_t region_reg,
	output float_word_t add_subt_data_a,
	output float_word_t add_subt_data_b,
	output logic op_add_subt, // Zero adds, one subtracts.
	output float_word_t data_output
);

	float_word_t result_sel;
	logic flip_sign;

	// Operands and operation for the variable being updated.
	always_comb
	begin
		case (ctrl.var_sel)
			VAR_Y:
			begin
				add_subt_data_a = y_cur;
				add_subt_data_b = x_shifted;
				op_add_subt = rotate_neg; // Y gains X on a positive turn.
			end
			VAR_Z:
			begin
				add_subt_data_a = z_cur;
				add_subt_data_b = atan_entry;
				op_add_subt = !rotate_neg; // Z loses the turned angle.
			end
			default:
			begin
				add_subt_data_a = x_cur;
				add_subt_data_b = y_shifted;
				op_add_subt = !rotate_neg;
			end
		endcase
	end

	// Region 01 negates cosine, 10 both, 11 sine.
	assign flip_sign = region_reg[0] ? (region_reg[1] == op_reg) : region_reg[1];

	always_comb
	begin
		result_sel = op_reg ? y_cur : x_cur;
		result_sel.fields.sign = result_sel.fields.sign ^ flip_sign;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			data_output <= '0;
		else if (ctrl.latch_out)
			data_output <= result_sel; // Held until the next computation latches.
	end

endmodule

`default_nettype wire

//--- datapath/xy_rotator.sv
`timescale 1ns/10ps
`default_nettype none

`include "cordic_config.svh"

module xy_rotator import cordic_float_pkg::*, cordic_ctrl_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire cordic_ctrl_t ctrl,
	input wire iter_t iter,
	input wire float_word_t result_add_subt,
	output float_word_t x_cur,
	output float_word_t y_cur,
	output float_word_t x_shifted, // X times 2^-iter.
	output float_word_t y_shifted // Y times 2^-iter.
);

	// Division by 2^i is a subtraction on the exponent field.
	// Values that would underflow, zero included, become a clean zero.
	function automatic float_word_t shift_exp(input float_word_t v, input iter_t i);
		float_word_t s;
		logic [`CORDIC_E-1:0] step;
		step = {{(`CORDIC_E - $bits(iter_t)){1'b0}}, i};
		s = v;
		if (v.fields.exponent == '0 || v.fields.exponent <= step)
			s.raw = '0;
		else
			s.fields.exponent = v.fields.exponent - step;
		return s;
	endfunction

	always_ff @(posedge clk)
	begin
		if (ctrl.load_init)
		begin
			x_cur.raw <= `CORDIC_X0; // Gain is folded into the start value.
			y_cur.raw <= '0;
		end
		else
		begin
			if (ctrl.load_x)
				x_cur <= result_add_subt;
			if (ctrl.load_y)
				y_cur <= result_add_subt;
		end
		// Both snapshots come from the values before this rotation's updates.
		if (ctrl.snap)
		begin
			x_shifted <= shift_exp(x_cur, iter);
			y_shifted <= shift_exp(y_cur, iter);
		end
	end

	// The preset and a result capture would fight over the same registers.
	assert property (@(posedge clk) disable iff (reset)
		ctrl.load_init |-> !(ctrl.load_x || ctrl.load_y || ctrl.load_z))
		else $error("initial load together with an adder result load");

endmodule

`default_nettype wire

//--- hw/cordic_coprocessor.sv
`timescale 1ns/10ps
`default_nettype none

module cordic_coprocessor import cordic_float_pkg::*, cordic_ctrl_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic beg_fsm_cordic, // Start pulse.
	input wire logic ack_cordic, // Result taken by the consumer.
	input wire logic operation, // One for sine, zero for cosine.
	input wire logic ready_add_subt, // Adder result valid, held until ack.
	input wire float_word_t data_in, // Angle in radians.
	input wire region_t shift_region_flag,
	input wire float_word_t result_add_subt,
	output logic ready_cordic,
	output logic beg_add_subt,
	output logic ack_add_subt,
	output logic op_add_subt, // One selects subtraction.
	output float_word_t add_subt_data_a,
	output float_word_t add_subt_data_b,
	output float_word_t data_output
);

	cordic_ctrl_t ctrl; // Strobes shared by the three datapath blocks.
	iter_t iter;
	float_word_t x_cur, y_cur, x_shifted, y_shifted;
	float_word_t z_cur, atan_entry;
	logic rotate_neg; // Z was negative at the snapshot.
	logic op_reg;
	region_t region_reg;

	////////////////////
	// Control

	cordic_fsm fsm_i
	(
		.clk (clk),
		.reset (reset),
		.beg_fsm_cordic (beg_fsm_cordic),
		.ack_cordic (ack_cordic),
		.ready_add_subt (ready_add_subt),
		.ctrl (ctrl),
		.iter (iter),
		.ready_cordic (ready_cordic),
		.beg_add_subt (beg_add_subt),
		.ack_add_subt (ack_add_subt)
	);

	////////////////////
	// Datapath

	xy_rotator xy_i
	(
		.clk (clk),
		.reset (reset),
		.ctrl (ctrl),
		.iter (iter),
		.result_add_subt (result_add_subt),
		.x_cur (x_cur),
		.y_cur (y_cur),
		.x_shifted (x_shifted),
		.y_shifted (y_shifted)
	);

	angle_path angle_i
	(
		.clk (clk),
		.reset (reset),
		.ctrl (ctrl),
		.iter (iter),
		.data_in (data_in),
		.result_add_subt (result_add_subt),
		.operation (operation),
		.shift_region_flag (shift_region_flag),
		.z_cur (z_cur),
		.atan_entry (atan_entry),
		.rotate_neg (rotate_neg),
		.op_reg (op_reg),
		.region_reg (region_reg)
	);

	iteration_combiner combiner_i
	(
		.clk (clk),
		.reset (reset),
		.ctrl (ctrl),
		.x_cur (x_cur),
		.y_cur (y_cur),
		.x_shifted (x_shifted),
		.y_shifted (y_shifted),
		.z_cur (z_cur),
		.atan_entry (atan_entry),
		.rotate_neg (rotate_neg),
		.op_reg (op_reg),
		.region_reg (region_reg),
		.add_subt_data_a (add_subt_data_a),
		.add_subt_data_b (add_subt_data_b),
		.op_add_subt (op_add_subt),
		.data_output (data_output)
	);

endmodule

`default_nettype wire

//--- hw/cordic_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "cordic_config.svh"

module cordic_fsm import cordic_float_pkg::*, cordic_ctrl_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic beg_fsm_cordic,
	input wire logic ack_cordic,
	input wire logic ready_add_subt,
	output cordic_ctrl_t ctrl,
	output iter_t iter, // Current rotation, counted up from zero.
	output logic ready_cordic,
	output logic beg_add_subt,
	output logic ack_add_subt
);

	fsm_state_t state, state_next;
	var_sel_t var_cnt; // Variable of the current adder exchange.
	logic last_iter;

	assign last_iter = (iter == iter_t'(`CORDIC_ITERS - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= ST_IDLE;
		else
			state <= state_next;
	end

	////////////////////
	// Counters

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			iter <= '0;
			var_cnt <= VAR_X;
		end
		else
		begin
			case (state)
				ST_LOAD:
				begin
					iter <= '0; // Fresh computation.
					var_cnt <= VAR_X;
				end
				ST_WAIT:
				begin
					// X, Y, Z, then back to X for the next rotation.
					if (ready_add_subt)
						var_cnt <= (var_cnt == VAR_Z) ? VAR_X : var_sel_t'(var_cnt + 2'd1);
				end
				ST_NEXT:
				begin
					if (!last_iter)
						iter <= iter + 1'b1;
				end
				default:
				begin
				end
			endcase
		end
	end

	////////////////////
	// Next state and strobes

	always_comb
	begin
		state_next = state;
		ctrl = '0;
		ctrl.var_sel = var_cnt; // Operands follow the counter in every state.
		beg_add_subt = 1'b0;
		ack_add_subt = 1'b0;
		ready_cordic = 1'b0;
		case (state)
			ST_IDLE:
			begin
				// Inputs are captured on the edge that ends the start cycle.
				ctrl.load_init = beg_fsm_cordic;
				if (beg_fsm_cordic)
					state_next = ST_LOAD;
			end
			ST_LOAD:
				state_next = ST_SNAP;
			ST_SNAP:
			begin
				ctrl.snap = 1'b1;
				state_next = ST_REQUEST;
			end
			ST_REQUEST:
			begin
				beg_add_subt = 1'b1; // One cycle only.
				state_next = ST_WAIT;
			end
			ST_WAIT:
			begin
				if (ready_add_subt)
				begin
					ack_add_subt = 1'b1; // Result is taken on this same edge.
					ctrl.load_x = (var_cnt == VAR_X);
					ctrl.load_y = (var_cnt == VAR_Y);
					ctrl.load_z = (var_cnt == VAR_Z);
					state_next = (var_cnt == VAR_Z) ? ST_NEXT : ST_REQUEST;
				end
			end
			ST_NEXT:
				state_next = last_iter ? ST_LATCH : ST_SNAP;
			ST_LATCH:
			begin
				ctrl.latch_out = 1'b1;
				state_next = ST_DONE;
			end
			ST_DONE:
			begin
				ready_cordic = 1'b1; // Held until the consumer acknowledges.
				if (ack_cordic)
					state_next = ST_IDLE;
			end
			default:
				state_next = ST_IDLE;
		endcase
	end

	// The adder sees a new start only after it has withdrawn the previous result.
	assert property (@(posedge clk) disable iff (reset) beg_add_subt |-> !ready_add_subt)
		else $error("adder start while the previous result is still presented");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cordic_coprocessor \
	-f cordic_coprocessor.f -o sim_cordic > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed."; exit 1; }

./obj_dir/sim_cordic > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed."; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a result."; exit 1; }
echo "Simulation passed."

//--- verif/cordic_stimulus.txt
// operation (1 sine, 0 cosine)  region  angle (hex float, radians)
// expected (hex float) is sin or cos of the angle before the region sign rule
1 0 3f000000 3ef57744
0 0 3f000000 3f60a940
1 1 3f800000 3f576aa4
0 1 3f800000 3f0a5140
1 2 3e800000 3e7d5777
0 2 3e800000 3f780aa5
1 3 3f400000 3f2e7fe1
0 3 3f400000 3f3b4ff6
1 0 3fc00000 3f7f5bd5
0 1 3fc00000 3d90deaa
1 2 3e000000 3dff5577
0 3 3e000000 3f7e00ab
1 3 3fa00000 3f72f0a8
0 0 3fa00000 3ea171ef
1 0 bf000000 bef57744
0 2 bf000000 3f60a940
0 0 00000000 3f800000

//--- verif/tb_cordic_coprocessor.sv
`timescale 1ns/10ps
`default_nettype none

`include "cordic_config.svh"

module tb_cordic_coprocessor;

	localparam int MAX_CASES = 64; // Room in the stimulus memory.
	localparam int REQS_PER_CASE = 3 * `CORDIC_ITERS; // X, Y and Z once per rotation.
	localparam real TOLERANCE = 2.0e-4;
	localparam real GAIN_INV = 0.607252935; // Start value of X.

	logic clk;
	logic reset;
	logic beg_fsm_cordic;
	logic ack_cordic;
	logic operation;
	logic ready_add_subt;
	logic [31:0] data_in;
	logic [1:0] shift_region_flag;
	logic [31:0] result_add_subt;
	logic ready_cordic;
	logic beg_add_subt;
	logic ack_add_subt;
	logic op_add_subt;
	logic [31:0] add_subt_data_a;
	logic [31:0] add_subt_data_b;
	logic [31:0] data_output;

	logic [31:0] stim_mem [0:4*MAX_CASES-1]; // Four words per case.
	logic [31:0] atan_tab [0:`CORDIC_ITERS-1];
	int num_cases;
	logic cases_loaded;
	int errors;
	int total_reqs;
	logic [31:0] rng;

	// Reference copies of X, Y and Z. Every adder exchange moves them one step.
	logic [31:0] mx, my, mz;
	logic [31:0] msx, msy, matan; // Snapshot taken before the X request.
	logic mneg;
	int req_idx; // Requests seen in the current case.

	cordic_coprocessor dut_i
	(
		.clk (clk),
		.reset (reset),
		.beg_fsm_cordic (beg_fsm_cordic),
		.ack_cordic (ack_cordic),
		.operation (operation),
		.ready_add_subt (ready_add_subt),
		.data_in (data_in),
		.shift_region_flag (shift_region_flag),
		.result_add_subt (result_add_subt),
		.ready_cordic (ready_cordic),
		.beg_add_subt (beg_add_subt),
		.ack_add_subt (ack_add_subt),
		.op_add_subt (op_add_subt),
		.add_subt_data_a (add_subt_data_a),
		.add_subt_data_b (add_subt_data_b),
		.data_output (data_output)
	);

	always #50 clk = ~clk; // 100 ns period.

	////////////////////
	// Helpers

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Single precision to double. Denormals count as zero.
	function automatic real float_to_real(input logic [31:0] w);
		logic [10:0] de;
		if (w[30:23] == 8'd0)
			return 0.0;
		de = 11'(w[30:23]) + 11'd896; // Rebias from 127 to 1023.
		return $bitstoreal({w[31], de, w[22:0], 29'd0});
	endfunction

	// Double to single precision, round to nearest even, underflow flushed to zero.
	function automatic logic [31:0] real_to_float(input real r);
		logic [63:0] d;
		logic [24:0] man;
		logic [28:0] rest;
		int e;
		d = $realtobits(r);
		e = int'(d[62:52]) - 896;
		if (d[62:52] == 11'd0 || e <= 0)
			return {d[63], 31'd0};
		man = {2'b01, d[51:29]};
		rest = d[28:0]; // Bits that drop off the short mantissa.
		if (rest > 29'h1000_0000 || (rest == 29'h1000_0000 && man[0]))
			man = man + 25'd1;
		if (man[24])
		begin
			man = man >> 1; // Rounding carried into the next binade.
			e = e + 1;
		end
		if (e >= 255)
			return {d[63], 8'hff, 23'd0};
		return {d[63], 8'(e), man[22:0]};
	endfunction

	// Multiply by 2^-i on the exponent. Anything that would reach exponent zero is zero.
	function automatic logic [31:0] scale_down(input logic [31:0] w, input int i);
		if (int'(w[30:23]) <= i)
			return 32'd0;
		return {w[31], w[30:23] - 8'(i), w[22:0]};
	endfunction

	// True when the region negates the selected result.
	function automatic logic negate_result(input logic [1:0] region, input logic sine);
		case (region)
			2'b01: return !sine; // Cosine only.
			2'b10: return 1'b1;
			2'b11: return sine; // Sine only.
			default: return 1'b0;
		endcase
	endfunction

	task automatic report_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errors = errors + 1;
		$display("[FAIL] t=%0t %s expected %h (%f) got %h (%f)", $time, name, expected,
			float_to_real(expected), actual, float_to_real(actual));
	endtask

	task automatic report_bit(input string name, input logic expected, input logic actual);
		errors = errors + 1;
		$display("[FAIL] t=%0t %s expected %b got %b", $time, name, expected, actual);
	endtask

	task automatic report_problem(input string what);
		errors = errors + 1;
		$display("t=%0t problem: %s", $time, what);
	endtask

	////////////////////
	// Adder model

	initial
	begin
		logic [31:0] ea, eb, res;
		logic eop;
		int sel, it, delay;
		forever
		begin
			@(negedge clk);
			if (beg_add_subt)
			begin
				sel = req_idx % 3; // X, Y, Z order.
				it = req_idx / 3;
				if (it >= `CORDIC_ITERS)
					report_problem($sformatf("adder request %0d is past the last rotation", req_idx));
				else if (sel == 0)
				begin
					msx = scale_down(mx, it); // Both shifts use values before this rotation.
					msy = scale_down(my, it);
					matan = atan_tab[it];
					mneg = mz[31];
				end
				case (sel)
					0:
					begin
						ea = mx;
						eb = msy;
						eop = !mneg; // Subtract on a positive turn.
					end
					1:
					begin
						ea = my;
						eb = msx;
						eop = mneg;
					end
					default:
					begin
						ea = mz;
						eb = matan;
						eop = !mneg;
					end
				endcase
				if (add_subt_data_a !== ea)
					report_value("add_subt_data_a", ea, add_subt_data_a);
				if (add_subt_data_b !== eb)
					report_value("add_subt_data_b", eb, add_subt_data_b);
				if (op_add_subt !== eop)
					report_bit("op_add_subt", eop, op_add_subt);
				if (eop)
					res = real_to_float(float_to_real(ea) - float_to_real(eb));
				else
					res = real_to_float(float_to_real(ea) + float_to_real(eb));
				case (sel)
					0: mx = res;
					1: my = res;
					default: mz = res;
				endcase
				req_idx = req_idx + 1;
				total_reqs = total_reqs + 1;
				rng = xorshift(rng);
				delay = int'(rng[1:0]) + 1; // One to four cycles of latency.
				repeat (delay) @(posedge clk);
				result_add_subt <= res;
				ready_add_subt <= 1'b1;
				do
					@(negedge clk);
				while (!ack_add_subt);
				@(posedge clk);
				ready_add_subt <= 1'b0; // The level falls once the ack was seen.
			end
		end
	end

	////////////////////
	// Watchdog

	initial
	begin
		wait (cases_loaded);
		repeat (num_cases * REQS_PER_CASE * 8 + 16 + 32) @(posedge clk);
		$display("Watchdog expired before the last case finished.");
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////
	// Main sequence

	initial
	begin
		int k, n;
		logic op;
		logic [1:0] region;
		logic [31:0] angle, file_val, want, hold;
		real diff;
		clk = 1'b0;
		reset = 1'b1;
		beg_fsm_cordic = 1'b0;
		ack_cordic = 1'b0;
		operation = 1'b0;
		ready_add_subt = 1'b0;
		data_in = 32'd0;
		shift_region_flag = 2'd0;
		result_add_subt = 32'd0;
		errors = 0;
		total_reqs = 0;
		req_idx = 0;
		rng = 32'hd266;
		cases_loaded = 1'b0;
		for (k = 0; k < 4 * MAX_CASES; k = k + 1)
			stim_mem[k] = 32'hffff_ffff; // Marks the end of the file.
		$readmemh("verif/cordic_stimulus.txt", stim_mem);
		num_cases = 0;
		while (num_cases < MAX_CASES && stim_mem[4*num_cases] != 32'hffff_ffff)
			num_cases = num_cases + 1;
		for (k = 0; k < `CORDIC_ITERS; k = k + 1)
			atan_tab[k] = real_to_float($atan(2.0 ** (-k)));
		cases_loaded = 1'b1;
		if (num_cases == 0)
			report_problem("no test cases were read from the stimulus file");

		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		// Idle outputs after reset.
		if (ready_cordic !== 1'b0)
			report_bit("ready_cordic", 1'b0, ready_cordic);
		if (beg_add_subt !== 1'b0)
			report_bit("beg_add_subt", 1'b0, beg_add_subt);
		if (ack_add_subt !== 1'b0)
			report_bit("ack_add_subt", 1'b0, ack_add_subt);
		if (data_output !== 32'd0)
			report_value("data_output", 32'd0, data_output);

		for (k = 0; k < num_cases; k = k + 1)
		begin
			op = stim_mem[4*k][0];
			region = stim_mem[4*k+1][1:0];
			angle = stim_mem[4*k+2];
			file_val = stim_mem[4*k+3];
			want = {file_val[31] ^ negate_result(region, op), file_val[30:0]};
			mx = real_to_float(GAIN_INV);
			my = 32'd0;
			mz = angle; // Residual angle starts at the input.
			req_idx = 0;
			@(posedge clk);
			beg_fsm_cordic <= 1'b1;
			operation <= op;
			shift_region_flag <= region;
			data_in <= angle;
			@(posedge clk);
			beg_fsm_cordic <= 1'b0;
			if (k % 3 == 1)
			begin
				// A start in the middle of a run, with other inputs, has to change nothing.
				wait (req_idx >= 7);
				@(posedge clk);
				beg_fsm_cordic <= 1'b1;
				operation <= !op;
				shift_region_flag <= ~region;
				data_in <= 32'h3fc00000;
				@(posedge clk);
				beg_fsm_cordic <= 1'b0;
			end
			do
				@(negedge clk);
			while (!ready_cordic);

			if (req_idx != REQS_PER_CASE)
				report_problem($sformatf("case %0d made %0d adder requests, not %0d",
					k, req_idx, REQS_PER_CASE));
			if (data_output[31] !== want[31])
				report_bit("data_output[31]", want[31], data_output[31]);
			diff = float_to_real(data_output) - float_to_real(want);
			if (diff < 0.0)
				diff = -diff;
			if (diff > TOLERANCE)
				report_value("data_output", want, data_output);

			// Late consumer. The result must sit still until the ack.
			hold = data_output;
			rng = xorshift(rng);
			n = int'(rng[2:0]);
			repeat (n)
			begin
				@(negedge clk);
				if (ready_cordic !== 1'b1)
					report_bit("ready_cordic", 1'b1, ready_cordic);
				if (data_output !== hold)
					report_value("data_output", hold, data_output);
			end
			@(posedge clk);
			ack_cordic <= 1'b1;
			@(posedge clk);
			ack_cordic <= 1'b0;
			@(negedge clk);
			if (ready_cordic !== 1'b0)
				report_bit("ready_cordic", 1'b0, ready_cordic); // Back in idle.
		end

		$display("Cases %0d, adder requests %0d, errors %0d", num_cases, total_reqs, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
